/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Byte address, instructions on word boundaries
`define PC_WIDTH 10

`define WORD_WIDTH 32

// Instruction store, indexed by pc[9:2]
`define IMEM_DEPTH 256
`define IMEM_ADDR_WIDTH 8

`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// JAL return address destination
`define LINK_REG 30

`endif

/* logic/isa_pkg.sv */
`include "core_cfg.svh"

package isa_pkg;

	// Opcode field, instr[30:25]
	typedef enum logic [5:0] {
		nop  = 6'd0,
		movi = 6'd1,
		ty_b = 6'd2,
		ty_j = 6'd3,
		jr   = 6'd4
	} opcode_e;

	// Branch flavour, instr[14]
	typedef enum logic {
		beq = 1'b0,
		bne = 1'b1
	} sub_op_b_e;

	// Jump flavour, instr[24]
	typedef enum logic {
		jj  = 1'b0,
		jal = 1'b1
	} sub_op_j_e;

	typedef struct packed {
		opcode_e                     opcode;
		sub_op_b_e                   sub_op_b;
		sub_op_j_e                   sub_op_j;
		logic [`REG_ADDR_WIDTH-1:0]  rt;
		logic [`REG_ADDR_WIDTH-1:0]  ra;
		logic [`REG_ADDR_WIDTH-1:0]  rb;
		logic [13:0]                 imm_14bit;
		logic [23:0]                 imm_24bit;
		// MOVI result, imm_14bit sign extended
		logic [`WORD_WIDTH-1:0]      imm_sext;
	} decoded_instr_t;

endpackage

/* logic/pipe_pkg.sv */
`include "core_cfg.svh"

package pipe_pkg;

	typedef enum logic [1:0] {
		pc_4,
		pc_14bit,
		pc_24bit,
		pc_register
	} pc_select_e;

	// REG1 contents
	typedef struct packed {
		logic                    valid;
		logic [`PC_WIDTH-1:0]    pc;
		logic [`WORD_WIDTH-1:0]  instr;
	} fetch_bundle_t;

	// Decode back to the program counter
	typedef struct packed {
		logic                    valid;
		pc_select_e              select;
		logic                    link;
		logic [`PC_WIDTH-1:0]    pc;
		logic [13:0]             imm_14bit;
		logic [23:0]             imm_24bit;
		logic [`WORD_WIDTH-1:0]  reg_rb_data;
	} redirect_t;

	// Retire record
	typedef struct packed {
		logic                        valid;
		logic [`PC_WIDTH-1:0]        pc;
		logic                        write_en;
		logic [`REG_ADDR_WIDTH-1:0]  write_index;
		logic [`WORD_WIDTH-1:0]      write_data;
	} commit_t;

endpackage

/* logic/pc.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module pc (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  enable_pc,
	input  logic                  do_hazard,
	input  pipe_pkg::redirect_t   redirect,
	output logic [`PC_WIDTH-1:0]  current_pc,
	output logic                  do_flush_reg1,
	output logic                  do_jump_link
);
	import pipe_pkg::*;

	pc_select_e select_pc;
	logic [`PC_WIDTH-1:0] next_pc;
	logic [`WORD_WIDTH-1:0] offset_14bit;
	logic [`WORD_WIDTH-1:0] offset_24bit;

	// Sequential flow unless decode resolved a taken branch or jump
	always_comb begin
		if (redirect.valid) begin
			select_pc = redirect.select;
		end else begin
			select_pc = pc_4;
		end
	end

	assign do_flush_reg1 = (select_pc != pc_4);
	assign do_jump_link = redirect.valid && redirect.link;

	// Word offsets, sign extended then cut to PC width
	assign offset_14bit = {{22{redirect.imm_14bit[13]}}, redirect.imm_14bit[7:0], 2'b00};
	assign offset_24bit = {{22{redirect.imm_24bit[23]}}, redirect.imm_24bit[7:0], 2'b00};

	always_comb begin
		case (select_pc)
			pc_14bit: begin
				next_pc = redirect.pc + offset_14bit[`PC_WIDTH-1:0];
			end
			pc_24bit: begin
				next_pc = redirect.pc + offset_24bit[`PC_WIDTH-1:0];
			end
			pc_register: begin
				next_pc = {redirect.reg_rb_data[`PC_WIDTH-1:2], 2'b00};
			end
			default: begin
				next_pc = current_pc + `PC_WIDTH'(4);
			end
		endcase
	end

	// A redirect loads its target even while run is low
	always_ff @(posedge clock) begin
		if (reset) begin
			current_pc <= '0;
		end else if (!do_hazard && (do_flush_reg1 || enable_pc)) begin
			current_pc <= next_pc;
		end
	end

endmodule

/* logic/instr_mem.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module instr_mem (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         load_en,
	input  logic [`IMEM_ADDR_WIDTH-1:0]  load_addr,
	input  logic [`WORD_WIDTH-1:0]       load_data,
	input  logic [`PC_WIDTH-1:0]         current_pc,
	input  logic                         do_hazard,
	input  logic                         do_flush_reg1,
	output pipe_pkg::fetch_bundle_t      reg1
);

	logic [`WORD_WIDTH-1:0] mem [`IMEM_DEPTH];
	logic [`PC_WIDTH-1:0] last_pc;
	logic refetch;
	logic pc_fresh;

	// Word at this PC not captured yet
	assign pc_fresh = refetch || (current_pc != last_pc);

	always_ff @(posedge clock) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end
	end

	// REG1, frozen by hazard, squashed by a taken redirect
	always_ff @(posedge clock) begin
		if (reset) begin
			reg1.valid <= 1'b0;
			refetch <= 1'b1;
			last_pc <= '0;
		end else if (!do_hazard) begin
			reg1.valid <= pc_fresh && !do_flush_reg1 && !load_en;
			reg1.pc <= current_pc;
			reg1.instr <= mem[current_pc[`PC_WIDTH-1:2]];
			// Redirect target or freshly loaded word is read again
			refetch <= do_flush_reg1 || load_en;
			last_pc <= current_pc;
		end
	end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module reg_file (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        write_en,
	input  logic [`REG_ADDR_WIDTH-1:0]  write_addr,
	input  logic [`WORD_WIDTH-1:0]      write_data,
	input  logic [`REG_ADDR_WIDTH-1:0]  rt_addr,
	input  logic [`REG_ADDR_WIDTH-1:0]  ra_addr,
	input  logic [`REG_ADDR_WIDTH-1:0]  rb_addr,
	output logic [`WORD_WIDTH-1:0]      rt_data,
	output logic [`WORD_WIDTH-1:0]      ra_data,
	output logic [`WORD_WIDTH-1:0]      rb_data
);

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// Old value until the edge
	assign rt_data = regs[rt_addr];
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

endmodule

/* logic/decode.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module decode (
	input  logic                     clock,
	input  logic                     reset,
	input  pipe_pkg::fetch_bundle_t  reg1,
	input  logic                     do_hazard,
	input  logic                     do_jump_link,
	output pipe_pkg::redirect_t      redirect,
	output pipe_pkg::commit_t        commit
);
	import isa_pkg::*;
	import pipe_pkg::*;

	decoded_instr_t dec;
	commit_t commit_next;
	logic resolve;
	logic rt_ra_equal;
	logic [`WORD_WIDTH-1:0] rt_data;
	logic [`WORD_WIDTH-1:0] ra_data;
	logic [`WORD_WIDTH-1:0] rb_data;
	logic write_en;
	logic [`REG_ADDR_WIDTH-1:0] write_addr;
	logic [`WORD_WIDTH-1:0] write_data;
	logic [`PC_WIDTH-1:0] return_pc;

	always_comb begin
		case (reg1.instr[30:25])
			ty_b, ty_j, jr, movi: dec.opcode = opcode_e'(reg1.instr[30:25]);
			default: dec.opcode = nop;
		endcase
		dec.sub_op_b = sub_op_b_e'(reg1.instr[14]);
		dec.sub_op_j = sub_op_j_e'(reg1.instr[24]);
		dec.rt = reg1.instr[24:20];
		dec.ra = reg1.instr[19:15];
		dec.rb = reg1.instr[14:10];
		dec.imm_14bit = reg1.instr[13:0];
		dec.imm_24bit = reg1.instr[23:0];
		dec.imm_sext = {{18{reg1.instr[13]}}, reg1.instr[13:0]};
	end

	reg_file u_reg_file (
		.clock      (clock),
		.reset      (reset),
		.write_en   (write_en),
		.write_addr (write_addr),
		.write_data (write_data),
		.rt_addr    (dec.rt),
		.ra_addr    (dec.ra),
		.rb_addr    (dec.rb),
		.rt_data    (rt_data),
		.ra_data    (ra_data),
		.rb_data    (rb_data)
	);

	// Nothing resolves while frozen
	assign resolve = reg1.valid && !do_hazard;
	assign rt_ra_equal = (rt_data == ra_data);
	assign return_pc = reg1.pc + `PC_WIDTH'(4);

	always_comb begin
		redirect.valid = resolve;
		redirect.select = pc_4;
		redirect.link = 1'b0;
		redirect.pc = reg1.pc;
		redirect.imm_14bit = dec.imm_14bit;
		redirect.imm_24bit = dec.imm_24bit;
		redirect.reg_rb_data = rb_data;
		case (dec.opcode)
			ty_b: begin
				if ((dec.sub_op_b == beq && rt_ra_equal) ||
					(dec.sub_op_b == bne && !rt_ra_equal)) begin
					redirect.select = pc_14bit;
				end
			end
			ty_j: begin
				redirect.select = pc_24bit;
				redirect.link = (dec.sub_op_j == jal);
			end
			jr: redirect.select = pc_register;
			default: ;
		endcase
	end

	// MOVI into rt, JAL return address into the link register
	always_comb begin
		write_en = 1'b0;
		write_addr = dec.rt;
		write_data = dec.imm_sext;
		if (resolve && dec.opcode == movi) begin
			write_en = 1'b1;
		end else if (do_jump_link) begin
			write_en = 1'b1;
			write_addr = `REG_ADDR_WIDTH'(`LINK_REG);
			write_data = {{(`WORD_WIDTH-`PC_WIDTH){1'b0}}, return_pc};
		end
	end

	always_comb begin
		commit_next.valid = resolve;
		commit_next.pc = reg1.pc;
		commit_next.write_en = write_en;
		commit_next.write_index = write_addr;
		commit_next.write_data = write_data;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			commit.valid <= 1'b0;
		end else begin
			commit <= commit_next;
		end
	end

endmodule

/* logic/fetch_core.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module fetch_core (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         run,
	input  logic                         hazard,
	input  logic                         load_en,
	input  logic [`IMEM_ADDR_WIDTH-1:0]  load_addr,
	input  logic [`WORD_WIDTH-1:0]       load_data,
	output logic [`PC_WIDTH-1:0]         current_pc,
	output pipe_pkg::commit_t            commit
);
	import pipe_pkg::*;

	fetch_bundle_t reg1;
	redirect_t redirect;
	logic do_flush_reg1;
	logic do_jump_link;

	pc u_pc (
		.clock         (clock),
		.reset         (reset),
		.enable_pc     (run),
		.do_hazard     (hazard),
		.redirect      (redirect),
		.current_pc    (current_pc),
		.do_flush_reg1 (do_flush_reg1),
		.do_jump_link  (do_jump_link)
	);

	instr_mem u_instr_mem (
		.clock         (clock),
		.reset         (reset),
		.load_en       (load_en),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.current_pc    (current_pc),
		.do_hazard     (hazard),
		.do_flush_reg1 (do_flush_reg1),
		.reg1          (reg1)
	);

	decode u_decode (
		.clock        (clock),
		.reset        (reset),
		.reg1         (reg1),
		.do_hazard    (hazard),
		.do_jump_link (do_jump_link),
		.redirect     (redirect),
		.commit       (commit)
	);

endmodule

/* verification/fetch_core_tb.sv */
`timescale 1ns/1ns
`include "core_cfg.svh"

module fetch_core_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CLOCK_PERIOD = 8;
	localparam int NUM_COMMITS = 600;
	localparam int STALL_BUDGET = 800;
	// Covers reset, load, four cycles per commit at worst and every stall cycle
	localparam int WATCHDOG_CYCLES = 4 + `IMEM_DEPTH + NUM_COMMITS * 4 + STALL_BUDGET;

	logic clock;
	logic reset;
	logic run;
	logic hazard;
	logic load_en;
	logic [`IMEM_ADDR_WIDTH-1:0] load_addr;
	logic [`WORD_WIDTH-1:0] load_data;
	logic [`PC_WIDTH-1:0] current_pc;
	commit_t commit;

	logic [31:0] rng_state = 32'd50091;
	logic [31:0] prog_words [`IMEM_DEPTH];
	logic [31:0] model_regs [`REG_COUNT];
	logic [`PC_WIDTH-1:0] model_pc;
	int commit_count;
	int hazard_left;
	int run_low_left;
	int stall_budget;

	fetch_core dut (.*);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Low byte counts words and the sign bit makes the step negative
	function automatic logic [`PC_WIDTH-1:0] branch_target(input logic [`PC_WIDTH-1:0] base,
			input logic sign, input logic [7:0] mag);
		int words;
		words = sign ? int'(mag) - 256 : int'(mag);
		return base + `PC_WIDTH'(words * 4);
	endfunction

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic build_program();
		logic [31:0] r;
		logic [31:0] f;
		logic [31:0] word;
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			r = next_random();
			f = next_random();
			word = f;
			if (r[3:0] < 5) begin
				// Small registers and values so that BEQ often finds a match
				word[30:25] = movi;
				word[24:20] = {3'b000, f[1:0]};
				case (f[5:4])
					2'd0: word[13:0] = {4'b0000, f[17:8]};
					2'd1: word[13:0] = 14'h3fff - 14'(f[7:6]);
					default: word[13:0] = 14'(f[7:6]);
				endcase
			end else if (r[3:0] < 10) begin
				word[30:25] = ty_b;
				word[24:20] = {3'b000, f[1:0]};
				word[19:15] = {3'b000, f[3:2]};
				word[13] = (f[7:5] == 3'd0);
				word[7:0] = word[13] ? 8'hff - 8'(f[18:16]) : 8'd1 + 8'(f[18:16]);
			end else if (r[3:0] < 12) begin
				// Forward jumps only
				word[30:25] = ty_j;
				word[23] = 1'b0;
				word[7:0] = 8'd1 + 8'(f[18:16]);
			end else if (r[3:0] == 12) begin
				word[30:25] = jr;
				word[14:10] = f[4] ? 5'(`LINK_REG) : {3'b000, f[3:2]};
			end else begin
				case (word[30:25])
					movi, ty_b, ty_j, jr: word[30:25] = nop;
					default: ;
				endcase
			end
			prog_words[i] = word;
		end
	endtask

	task automatic check_commit();
		logic [31:0] word;
		logic [`PC_WIDTH-1:0] seq_pc;
		logic [`PC_WIDTH-1:0] next_pc;
		logic exp_we;
		logic [4:0] exp_index;
		logic [31:0] exp_data;
		word = prog_words[model_pc[`PC_WIDTH-1:2]];
		seq_pc = model_pc + `PC_WIDTH'(4);
		next_pc = seq_pc;
		exp_we = 1'b0;
		exp_index = word[24:20];
		// Immediate taken as a signed 14-bit number
		exp_data = word[13] ? 32'(word[13:0]) - 32'h4000 : 32'(word[13:0]);
		case (word[30:25])
			movi: exp_we = 1'b1;
			ty_b: begin
				// BEQ taken on equal and BNE on different
				if ((model_regs[word[24:20]] == model_regs[word[19:15]]) != word[14]) begin
					next_pc = branch_target(model_pc, word[13], word[7:0]);
				end
			end
			ty_j: begin
				next_pc = branch_target(model_pc, word[23], word[7:0]);
				if (word[24]) begin
					exp_we = 1'b1;
					exp_index = 5'(`LINK_REG);
					exp_data = 32'(seq_pc);
				end
			end
			jr: next_pc = `PC_WIDTH'(model_regs[word[14:10]]) & ~`PC_WIDTH'(3);
			default: ;
		endcase
		compare($sformatf("commit %0d pc", commit_count), 32'(model_pc), 32'(commit.pc));
		compare($sformatf("commit %0d write enable", commit_count), 32'(exp_we),
			32'(commit.write_en));
		if (exp_we) begin
			compare($sformatf("commit %0d write index", commit_count), 32'(exp_index),
				32'(commit.write_index));
			compare($sformatf("commit %0d write data", commit_count), exp_data,
				commit.write_data);
			model_regs[exp_index] = exp_data;
		end
		model_pc = next_pc;
	endtask

	// Random hazard bursts and run-low periods until the stall budget is used
	task automatic drive_controls();
		logic [31:0] r;
		if (hazard_left == 0 && run_low_left == 0 && stall_budget >= 16) begin
			r = next_random();
			if (r[4:0] == 5'd0 || r[4:0] == 5'd2) begin
				hazard_left = 1 + r[7:5];
			end
			if (r[4:0] == 5'd1 || r[4:0] == 5'd2) begin
				run_low_left = 1 + r[10:8];
			end
			stall_budget -= hazard_left + run_low_left;
		end
		hazard = (hazard_left != 0);
		run = (run_low_left == 0);
		if (hazard_left != 0) begin
			hazard_left--;
		end
		if (run_low_left != 0) begin
			run_low_left--;
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("error: commits stopped arriving, %0d of %0d retired", commit_count,
			NUM_COMMITS);
		abort_run();
	end

	initial begin
		reset = 1'b1;
		run = 1'b0;
		hazard = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		model_pc = '0;
		commit_count = 0;
		hazard_left = 0;
		run_low_left = 0;
		stall_budget = STALL_BUDGET;
		for (int i = 0; i < `REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		build_program();
		repeat (4) @(negedge clock);
		reset = 1'b0;
		compare("reset pc", 32'd0, 32'(current_pc));
		compare("reset commit valid", 32'd0, 32'(commit.valid));
		// Program load with the core idle
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			load_en = 1'b1;
			load_addr = `IMEM_ADDR_WIDTH'(i);
			load_data = prog_words[i];
			@(negedge clock);
			compare("pc during load", 32'd0, 32'(current_pc));
			compare("commit valid during load", 32'd0, 32'(commit.valid));
		end
		load_en = 1'b0;
		while (commit_count < NUM_COMMITS) begin
			@(negedge clock);
			// hazard still holds the level seen at the last rising edge
			if (commit.valid) begin
				if (hazard) begin
					$display("error: an instruction retired while hazard was high");
					abort_run();
				end
				check_commit();
				commit_count++;
			end
			drive_controls();
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/pc.sv
logic/instr_mem.sv
logic/reg_file.sv
logic/decode.sv
logic/fetch_core.sv
verification/fetch_core_tb.sv
